// File: verilog/capture_mon_pkg.sv
package capture_mon_pkg;

  localparam int ADDR_W    = 12;
  localparam int STRB_W    = 8;
  localparam int CNT_W     = 32;
  localparam int SRC_W     = 4;
  localparam int SAMPLES_W = 3;

  // 16-bit samples packed low first into a 64-bit beat
  localparam logic [STRB_W-1:0] STRB_1S = 8'h03;
  localparam logic [STRB_W-1:0] STRB_2S = 8'h0F;
  localparam logic [STRB_W-1:0] STRB_3S = 8'h3F;
  localparam logic [STRB_W-1:0] STRB_4S = 8'hFF;

  // observed write side of one HP port
  typedef struct packed {
    logic              awvalid;
    logic              awready;
    logic [ADDR_W-1:0] awaddr;
    logic              wvalid;
    logic              wready;
    logic [STRB_W-1:0] wstrb;
  } axi_wr_t;

  typedef struct packed {
    logic                 valid;
    logic [SAMPLES_W-1:0] samples;
    logic [ADDR_W-1:0]    addr;
  } beat_t;

  typedef struct packed {
    logic             adc_hit;
    logic             axi_hit;
    logic [SRC_W-1:0] src;
  } trig_evt_t;

  // channel 0 counts at the time of the trigger
  typedef struct packed {
    logic [SRC_W-1:0] src;
    logic [CNT_W-1:0] adc_count;
    logic [CNT_W-1:0] axi_count;
  } trig_rec_t;

endpackage

// File: verilog/axi_beat_decoder.sv
`timescale 1ns/1ps

module axi_beat_decoder #(
  parameter int NUM_CH = 2
) (
  input  logic                     axi_clk,
  input  logic                     i_rst_n,
  input  capture_mon_pkg::axi_wr_t i_axi  [NUM_CH],
  output capture_mon_pkg::beat_t   o_beat [NUM_CH]
);

  typedef logic [capture_mon_pkg::SAMPLES_W-1:0] samples_t;

  // strobe pattern to sample count, unknown patterns count nothing
  function automatic samples_t strb_to_samples(
    input logic [capture_mon_pkg::STRB_W-1:0] strb
  );
    samples_t n;
    case (strb)
      capture_mon_pkg::STRB_1S: n = samples_t'(1);
      capture_mon_pkg::STRB_2S: n = samples_t'(2);
      capture_mon_pkg::STRB_3S: n = samples_t'(3);
      capture_mon_pkg::STRB_4S: n = samples_t'(4);
      default:                  n = '0;
    endcase
    return n;
  endfunction

  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch
    logic                   w_acc;
    logic                   aw_acc;
    capture_mon_pkg::beat_t beat_q;

    assign w_acc  = i_axi[ch].wvalid  && i_axi[ch].wready;
    assign aw_acc = i_axi[ch].awvalid && i_axi[ch].awready;

    always_ff @(posedge axi_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
        beat_q <= '0;
      end else begin
        beat_q.valid <= w_acc;
        if (w_acc) begin
          beat_q.samples <= strb_to_samples(i_axi[ch].wstrb);
        end else begin
          beat_q.samples <= '0;
        end
        // address is sticky until the next aw handshake
        if (aw_acc) begin
          beat_q.addr <= i_axi[ch].awaddr;
        end
      end
    end

    assign o_beat[ch] = beat_q;
  end

endmodule

// File: verilog/trig_delay_line.sv
`timescale 1ns/1ps

module trig_delay_line #(
  parameter int TRIG_DELAY = 2
) (
  input  logic                              axi_clk,
  input  logic                              i_rst_n,
  input  logic                              i_adc_trig,
  input  logic                              i_axi_trig,
  input  logic [capture_mon_pkg::SRC_W-1:0] i_trig_src,
  output capture_mon_pkg::trig_evt_t        o_evt
);

  logic [TRIG_DELAY-1:0]             adc_sr;
  logic [TRIG_DELAY-1:0]             axi_sr;
  logic [capture_mon_pkg::SRC_W-1:0] src_q;

  // one stage per cycle of delay, tap 0 takes the raw pulse
  always_ff @(posedge axi_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      adc_sr <= '0;
      axi_sr <= '0;
    end else begin
      adc_sr[0] <= i_adc_trig;
      axi_sr[0] <= i_axi_trig;
      for (int i = 1; i < TRIG_DELAY; i++) begin
        adc_sr[i] <= adc_sr[i-1];
        axi_sr[i] <= axi_sr[i-1];
      end
    end
  end

  // source only valid with the adc trigger
  always_ff @(posedge axi_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      src_q <= '0;
    end else if (i_adc_trig) begin
      src_q <= i_trig_src;
    end
  end

  assign o_evt = '{
    adc_hit: adc_sr[TRIG_DELAY-1],
    axi_hit: axi_sr[TRIG_DELAY-1],
    src:     src_q
  };

endmodule

// File: verilog/channel_counters.sv
`timescale 1ns/1ps

module channel_counters #(
  parameter int NUM_CH = 2
) (
  input  logic                               axi_clk,
  input  logic                               i_rst_n,
  input  logic [NUM_CH-1:0]                  i_adc_we,
  input  logic [NUM_CH-1:0]                  i_adc_dv,
  input  capture_mon_pkg::beat_t             i_beat      [NUM_CH],
  input  capture_mon_pkg::trig_evt_t         i_evt,
  output logic [capture_mon_pkg::CNT_W-1:0]  o_adc_count [NUM_CH],
  output logic [capture_mon_pkg::CNT_W-1:0]  o_axi_count [NUM_CH],
  output logic [capture_mon_pkg::ADDR_W-1:0] o_last_addr [NUM_CH],
  output logic                               o_trig_valid,
  output capture_mon_pkg::trig_rec_t         o_trig_rec
);

  typedef logic [capture_mon_pkg::CNT_W-1:0] cnt_t;

  logic trig_hit;

  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch
    cnt_t                              adc_cnt_q;
    cnt_t                              axi_cnt_q;
    logic [capture_mon_pkg::ADDR_W-1:0] addr_q;

    // one sample per cycle with we and dv both set
    always_ff @(posedge axi_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
        adc_cnt_q <= '0;
      end else if (i_adc_we[ch] && i_adc_dv[ch]) begin
        adc_cnt_q <= adc_cnt_q + cnt_t'(1);
      end
    end

    always_ff @(posedge axi_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
        axi_cnt_q <= '0;
      end else if (i_beat[ch].valid) begin
        axi_cnt_q <= axi_cnt_q + cnt_t'(i_beat[ch].samples);
      end
    end

    // decoder already holds the latest address, just follow it
    always_ff @(posedge axi_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
        addr_q <= '0;
      end else begin
        addr_q <= i_beat[ch].addr;
      end
    end

    assign o_adc_count[ch] = adc_cnt_q;
    assign o_axi_count[ch] = axi_cnt_q;
    assign o_last_addr[ch] = addr_q;
  end

  assign trig_hit = i_evt.adc_hit || i_evt.axi_hit;

  // snapshot of channel 0 as it stands at the hit edge
  always_ff @(posedge axi_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_trig_valid <= 1'b0;
      o_trig_rec   <= '0;
    end else begin
      o_trig_valid <= trig_hit;
      if (trig_hit) begin
        o_trig_rec <= '{
          src:       i_evt.src,
          adc_count: o_adc_count[0],
          axi_count: o_axi_count[0]
        };
      end
    end
  end

endmodule

// File: verilog/capture_mon_top.sv
`timescale 1ns/1ps

module capture_mon_top #(
  parameter int NUM_CH     = 2,
  parameter int TRIG_DELAY = 2
) (
  input  logic                               i_rst_n,
  input  logic                               axi_clk,
  input  capture_mon_pkg::axi_wr_t           i_axi       [NUM_CH],
  input  logic [NUM_CH-1:0]                  i_adc_we,
  input  logic [NUM_CH-1:0]                  i_adc_dv,
  input  logic                               i_adc_trig,
  input  logic                               i_axi_trig,
  input  logic [capture_mon_pkg::SRC_W-1:0]  i_trig_src,
  output logic [capture_mon_pkg::CNT_W-1:0]  o_adc_count [NUM_CH],
  output logic [capture_mon_pkg::CNT_W-1:0]  o_axi_count [NUM_CH],
  output logic [capture_mon_pkg::ADDR_W-1:0] o_last_addr [NUM_CH],
  output logic                               o_trig_valid,
  output capture_mon_pkg::trig_rec_t         o_trig_rec
);

  capture_mon_pkg::beat_t     beat [NUM_CH];
  capture_mon_pkg::trig_evt_t evt;

  // per channel handshake qualify and strobe decode
  axi_beat_decoder #(
    .NUM_CH (NUM_CH)
  ) u_beat_decoder (
    .axi_clk (axi_clk),
    .i_rst_n (i_rst_n),
    .i_axi   (i_axi),
    .o_beat  (beat)
  );

  trig_delay_line #(
    .TRIG_DELAY (TRIG_DELAY)
  ) u_trig_delay (
    .axi_clk    (axi_clk),
    .i_rst_n    (i_rst_n),
    .i_adc_trig (i_adc_trig),
    .i_axi_trig (i_axi_trig),
    .i_trig_src (i_trig_src),
    .o_evt      (evt)
  );

  // accumulators, last address and trigger record
  channel_counters #(
    .NUM_CH (NUM_CH)
  ) u_counters (
    .axi_clk      (axi_clk),
    .i_rst_n      (i_rst_n),
    .i_adc_we     (i_adc_we),
    .i_adc_dv     (i_adc_dv),
    .i_beat       (beat),
    .i_evt        (evt),
    .o_adc_count  (o_adc_count),
    .o_axi_count  (o_axi_count),
    .o_last_addr  (o_last_addr),
    .o_trig_valid (o_trig_valid),
    .o_trig_rec   (o_trig_rec)
  );

endmodule

// File: verif/capture_mon_tasks.svh
`ifndef CAPTURE_MON_TASKS_SVH
`define CAPTURE_MON_TASKS_SVH

// inputs change a little after the rising edge
task automatic next_cycle();
  @(posedge axi_clk);
  #1;
endtask

task automatic idle_cycles(input int n);
  repeat (n) next_cycle();
endtask

// low 2k bytes enabled is worth k samples, anything else nothing
function automatic int expected_samples(
  input logic [capture_mon_pkg::STRB_W-1:0] strb
);
  int n;
  n = 0;
  for (int k = 1; k <= 4; k++) begin
    if (strb == ((1 << (2 * k)) - 1)) begin
      n = k;
    end
  end
  return n;
endfunction

task automatic check_count(
  input logic [capture_mon_pkg::CNT_W-1:0] got,
  input logic [capture_mon_pkg::CNT_W-1:0] exp,
  input string                             what
);
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
  end
endtask

task automatic check_addr(
  input logic [capture_mon_pkg::ADDR_W-1:0] got,
  input logic [capture_mon_pkg::ADDR_W-1:0] exp,
  input string                              what
);
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
  end
endtask

task automatic check_trig_rec(
  input capture_mon_pkg::trig_rec_t got,
  input capture_mon_pkg::trig_rec_t exp,
  input string                      what
);
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED at %0t: %s got src %0h adc %0d axi %0d",
             $time, what, got.src, got.adc_count, got.axi_count);
    $display("  expected src %0h adc %0d axi %0d",
             exp.src, exp.adc_count, exp.axi_count);
  end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
  end
endtask

task automatic check_latency(input int got, input int exp, input string what);
  if (got != exp) begin
    errors++;
    $display("CHECK FAILED at %0t: %s got %0d cycles expected %0d", $time, what, got, exp);
  end
endtask

task automatic drive_beat(
  input int                                ch,
  input logic                              valid,
  input logic                              ready,
  input logic [capture_mon_pkg::STRB_W-1:0] strb
);
  axi_in[ch].wvalid = valid;
  axi_in[ch].wready = ready;
  axi_in[ch].wstrb  = strb;
  if (valid && ready) begin
    exp_axi[ch] += expected_samples(strb);
  end
  next_cycle();
  axi_in[ch].wvalid = 1'b0;
  axi_in[ch].wready = 1'b0;
  axi_in[ch].wstrb  = '0;
endtask

task automatic drive_addr(
  input int                                 ch,
  input logic                               ready,
  input logic [capture_mon_pkg::ADDR_W-1:0] addr
);
  axi_in[ch].awvalid = 1'b1;
  axi_in[ch].awready = ready;
  axi_in[ch].awaddr  = addr;
  if (ready) begin
    exp_addr[ch] = addr;
  end
  next_cycle();
  axi_in[ch].awvalid = 1'b0;
  axi_in[ch].awready = 1'b0;
  axi_in[ch].awaddr  = '0;
endtask

// one cycle trigger pulse, source driven alongside
task automatic pulse_trig(
  input logic                              adc,
  input logic                              axi,
  input logic [capture_mon_pkg::SRC_W-1:0] src
);
  adc_trig = adc;
  axi_trig = axi;
  trig_src = src;
  next_cycle();
  adc_trig = 1'b0;
  axi_trig = 1'b0;
  trig_src = '0;
endtask

task automatic wait_trig_valid(output int cycles, output bit seen);
  cycles = 0;
  seen   = 1'b0;
  while (!seen && cycles < TRIG_TIMEOUT) begin
    next_cycle();
    cycles++;
    if (trig_valid) begin
      seen = 1'b1;
    end
  end
  if (!seen) begin
    timeouts++;
    $display("timeout at %0t: trigger record never became valid within %0d cycles",
             $time, TRIG_TIMEOUT);
  end
endtask

task automatic check_all(input string phase);
  for (int ch = 0; ch < NUM_CH; ch++) begin
    check_count(adc_count[ch], exp_adc[ch], $sformatf("%s adc count ch%0d", phase, ch));
    check_count(axi_count[ch], exp_axi[ch], $sformatf("%s axi count ch%0d", phase, ch));
    check_addr(last_addr[ch], exp_addr[ch], $sformatf("%s last addr ch%0d", phase, ch));
  end
endtask

`endif

// File: verif/capture_mon_tb.sv
`timescale 1ns/1ps

module capture_mon_tb;

  localparam int NUM_CH       = 2;
  localparam int TRIG_DELAY   = 2;
  localparam int TRIG_TIMEOUT = 50;

  logic                               axi_clk;
  logic                               rst_n;
  capture_mon_pkg::axi_wr_t           axi_in    [NUM_CH];
  logic [NUM_CH-1:0]                  adc_we;
  logic [NUM_CH-1:0]                  adc_dv;
  logic                               adc_trig;
  logic                               axi_trig;
  logic [capture_mon_pkg::SRC_W-1:0]  trig_src;
  logic [capture_mon_pkg::CNT_W-1:0]  adc_count [NUM_CH];
  logic [capture_mon_pkg::CNT_W-1:0]  axi_count [NUM_CH];
  logic [capture_mon_pkg::ADDR_W-1:0] last_addr [NUM_CH];
  logic                               trig_valid;
  capture_mon_pkg::trig_rec_t         trig_rec;

  // reference model state
  logic [capture_mon_pkg::CNT_W-1:0]  exp_adc   [NUM_CH];
  logic [capture_mon_pkg::CNT_W-1:0]  exp_axi   [NUM_CH];
  logic [capture_mon_pkg::ADDR_W-1:0] exp_addr  [NUM_CH];
  logic [capture_mon_pkg::SRC_W-1:0]  last_src;

  int errors;
  int timeouts;

  capture_mon_top #(
    .NUM_CH     (NUM_CH),
    .TRIG_DELAY (TRIG_DELAY)
  ) uut (
    .i_rst_n      (rst_n),
    .axi_clk      (axi_clk),
    .i_axi        (axi_in),
    .i_adc_we     (adc_we),
    .i_adc_dv     (adc_dv),
    .i_adc_trig   (adc_trig),
    .i_axi_trig   (axi_trig),
    .i_trig_src   (trig_src),
    .o_adc_count  (adc_count),
    .o_axi_count  (axi_count),
    .o_last_addr  (last_addr),
    .o_trig_valid (trig_valid),
    .o_trig_rec   (trig_rec)
  );

  `include "capture_mon_tasks.svh"

  initial begin
    axi_clk = 1'b0;
    forever #4 axi_clk = ~axi_clk;
  end

  task automatic test_reset_state();
    check_all("reset");
    check_trig_rec(trig_rec, '0, "trigger record after reset");
    for (int i = 0; i < 20; i++) begin
      next_cycle();
      check_flag(trig_valid, 1'b0, "trig valid while idle");
    end
  endtask

  task automatic test_adc_counting();
    int unsigned r;
    for (int i = 0; i < 60; i++) begin
      r = $urandom;
      adc_we = r[NUM_CH-1:0];
      adc_dv = r[16 +: NUM_CH];
      for (int ch = 0; ch < NUM_CH; ch++) begin
        if (adc_we[ch] && adc_dv[ch]) begin
          exp_adc[ch]++;
        end
      end
      next_cycle();
    end
    adc_we = '0;
    adc_dv = '0;
    idle_cycles(2);
    check_all("adc");
  endtask

  task automatic test_axi_strobes();
    logic [capture_mon_pkg::STRB_W-1:0] pats [4];
    logic [capture_mon_pkg::STRB_W-1:0] strb;
    int unsigned                        r;
    int                                 ch;
    pats[0] = capture_mon_pkg::STRB_1S;
    pats[1] = capture_mon_pkg::STRB_2S;
    pats[2] = capture_mon_pkg::STRB_3S;
    pats[3] = capture_mon_pkg::STRB_4S;
    for (int c = 0; c < NUM_CH; c++) begin
      for (int k = 0; k < 4; k++) begin
        drive_beat(c, 1'b1, 1'b1, pats[k]);
      end
      // stalled beat must not count
      drive_beat(c, 1'b1, 1'b0, capture_mon_pkg::STRB_4S);
    end
    for (int i = 0; i < 40; i++) begin
      r  = $urandom;
      ch = r[3:0] % NUM_CH;
      if (r[4]) begin
        strb = pats[r[6:5]];
      end else begin
        strb = r[15:8];
      end
      drive_beat(ch, r[17:16] != 2'b00, r[19:18] != 2'b00, strb);
      idle_cycles($urandom % 3);
    end
    idle_cycles(2);
    check_all("axi");
  endtask

  task automatic test_addr_capture();
    int unsigned r;
    for (int i = 0; i < 24; i++) begin
      r = $urandom;
      drive_addr(r[31:28] % NUM_CH, r[27:26] != 2'b00, r[capture_mon_pkg::ADDR_W-1:0]);
      idle_cycles($urandom % 2);
    end
    idle_cycles(2);
    check_all("address");
  endtask

  task automatic test_trig_record();
    capture_mon_pkg::trig_rec_t exp_rec;
    int unsigned                r;
    int                         cycles;
    bit                         seen;
    // nonzero so it differs from the reset source
    r        = $urandom % 15 + 1;
    last_src = r[capture_mon_pkg::SRC_W-1:0];
    pulse_trig(1'b1, 1'b0, last_src);
    wait_trig_valid(cycles, seen);
    if (seen) begin
      check_latency(cycles + 1, TRIG_DELAY + 1, "adc trigger latency");
      exp_rec.src       = last_src;
      exp_rec.adc_count = exp_adc[0];
      exp_rec.axi_count = exp_axi[0];
      check_trig_rec(trig_rec, exp_rec, "adc trigger record");
      next_cycle();
      check_flag(trig_valid, 1'b0, "trig valid after one cycle");
    end
    // move channel 0 counts so the second snapshot differs
    drive_beat(0, 1'b1, 1'b1, capture_mon_pkg::STRB_3S);
    adc_we[0] = 1'b1;
    adc_dv[0] = 1'b1;
    exp_adc[0]++;
    next_cycle();
    adc_we = '0;
    adc_dv = '0;
    idle_cycles(3);
    // source on the axi pulse is ignored
    pulse_trig(1'b0, 1'b1, ~last_src);
    wait_trig_valid(cycles, seen);
    if (seen) begin
      check_latency(cycles + 1, TRIG_DELAY + 1, "axi trigger latency");
      exp_rec.src       = last_src;
      exp_rec.adc_count = exp_adc[0];
      exp_rec.axi_count = exp_axi[0];
      check_trig_rec(trig_rec, exp_rec, "axi trigger record");
    end
    idle_cycles(2);
    check_all("trigger");
  endtask

  initial begin
    int unsigned seed;
    seed = 96;
    void'($urandom(seed));
    errors   = 0;
    timeouts = 0;
    rst_n    = 1'b0;
    adc_we   = '0;
    adc_dv   = '0;
    adc_trig = 1'b0;
    axi_trig = 1'b0;
    trig_src = '0;
    last_src = '0;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      axi_in[ch]   = '0;
      exp_adc[ch]  = '0;
      exp_axi[ch]  = '0;
      exp_addr[ch] = '0;
    end
    repeat (10) @(posedge axi_clk);
    #1;
    rst_n = 1'b1;

    test_reset_state();
    test_adc_counting();
    test_axi_strobes();
    test_addr_capture();
    test_trig_record();

    $display("summary: %0d check errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+verif
verilog/capture_mon_pkg.sv
verilog/axi_beat_decoder.sv
verilog/trig_delay_line.sv
verilog/channel_counters.sv
verilog/capture_mon_top.sv
verif/capture_mon_tb.sv
